// File: bench/conv_stimulus.hex
// per block: weights f0 taps 0-8, weights f1 taps 0-8, bias f0 f1, six pixel rows,
// then expected f0 and expected f1, two output rows per line
// block 0, ramp image, box filter and diagonal filter
0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0000 0000 0000 0000 0000 0000 0000 ff80
0010 0040
0001 0002 0003 0004 0005 0006
0007 0008 0009 000a 000b 000c
000d 000e 000f 0010 0011 0012
0013 0014 0015 0016 0017 0018
0019 001a 001b 001c 001d 001e
001f 0020 0021 0022 0023 0024
0022 002e 0034 003a 0040 0032 003d 0058 0061 006a 0073 0055
0061 008e 0097 00a0 00a9 0079 0085 00c4 00cd 00d6 00df 009d
00a9 00fa 0103 010c 0115 00c1 0082 00be 00c4 00ca 00d0 0092
003c 003b 003b 003a 003a 0040 0039 0039 003a 003a 003b 0045
0036 003c 003d 003d 003e 004b 0033 003f 0040 0040 0041 0051
0030 0042 0043 0043 0044 0057 0040 0059 005a 005b 005c 005d
// block 1, split sign image, large weights and negative biases
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
0000 4000 0000 0000 4000 0000 0000 0100 0000
c000 ff00
0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100
0100 0100 0100 0100 0100 0100
ff00 ff00 ff00 ff00 ff00 ff00
ff00 ff00 ff00 ff00 ff00 ff00
ff00 ff00 ff00 ff00 ff00 ff00
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
7fff 7fff 7fff 7fff 7fff 7fff 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
4000 4000 4000 4000 4000 4000 7fff 7fff 7fff 7fff 7fff 7fff
7e00 7e00 7e00 7e00 7e00 7e00 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// File: bench/tb_conv_layer.sv
`timescale 1ns/100ps

module tb_conv_layer import conv_pkg::*; ();

   localparam int CLOCK_PERIOD = 40;
   localparam int QUARTER      = CLOCK_PERIOD / 4;
   localparam int RESET_CYCLES = 3;

   // stimulus block layout, one block per image
   localparam int BIAS_OFFSET   = NUM_FILTERS * NUM_TAPS;
   localparam int PIXEL_OFFSET  = BIAS_OFFSET + NUM_FILTERS;
   localparam int RESULT_OFFSET = PIXEL_OFFSET + IMAGE_SIZE;
   localparam int BLOCK_WORDS   = RESULT_OFFSET + NUM_FILTERS * IMAGE_SIZE;
   localparam int NUM_BLOCKS    = 2;

   // three image runs, each with input beats, output beats and two passes
   localparam int RUN_COUNT     = 3;
   localparam int RUN_BEATS     = IMAGE_SIZE * (1 + NUM_FILTERS);
   localparam int RUN_PASSES    = NUM_FILTERS * (IMAGE_SIZE + CENTER_DELAY + 2);
   localparam int CYCLE_LIMIT   = 4 * RUN_COUNT * (RUN_BEATS + RUN_PASSES);

   logic          clock;
   logic          reset_n;
   apb_req_t      apb_req;
   apb_rsp_t      apb_rsp;
   feature_beat_t in_beat;
   logic          in_ready;
   feature_beat_t out_beat;
   logic          out_ready;

   logic [15:0] stim_mem [NUM_BLOCKS * BLOCK_WORDS];
   logic [31:0] lfsr;
   int          cycle_count;
   int          check_count;
   int          error_count;
   int          errors_before;
   int          test_count;

   conv_layer i_conv_layer (
      .clock(clock), .reset_n(reset_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
      .in_beat(in_beat), .in_ready(in_ready), .out_beat(out_beat), .out_ready(out_ready));

   initial begin
      clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) clock = ~clock;
   end

   // run limit, counts rising edges
   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clock);
         cycle_count++;
      end
      $display("timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
   end

   // -------------------------------------------------------------------
   // helpers
   // -------------------------------------------------------------------

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("FAIL %0t: %s got %h expected %h", $time, what, got, expected);
      end
   endtask

   task automatic finish_test(input string name);
      test_count++;
      $display("test %0d %s finished, %0d errors", test_count, name,
               error_count - errors_before);
      errors_before = error_count;
   endtask

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h8020_0003;
      end
      return state >> 1;
   endfunction

   task automatic take_random_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b    = lfsr[0];
   endtask

   // true one time in four
   task automatic draw_rare_event(output logic hit);
      logic a;
      logic b;
      take_random_bit(a);
      take_random_bit(b);
      hit = a && b;
   endtask

   // weight view: region 0, filter in 6:4, tap in 3:0
   function automatic logic [7:0] weight_address(input int filter, input int tap);
      return 8'(filter * 16 + tap);
   endfunction

   // bias view: region 1, filter in 6:4
   function automatic logic [7:0] bias_address(input int filter);
      return 8'(128 + filter * 16);
   endfunction

   // one apb transfer, setup then access phase, then idle
   task automatic apb_access(input logic write, input logic [7:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata,
                             output logic slverr);
      @(negedge clock);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(negedge clock);
      apb_req.penable = 1'b1;
      // response is settled well before the completing edge
      #QUARTER;
      rdata  = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      check_value("pready", apb_rsp.pready, 1'b1);
      @(negedge clock);
      apb_req = '0;
   endtask

   task automatic write_coefficients(input int block);
      int          base;
      logic [15:0] rdata;
      logic        slverr;
      base = block * BLOCK_WORDS;
      for (int f = 0; f < NUM_FILTERS; f++) begin
         for (int t = 0; t < NUM_TAPS; t++) begin
            apb_access(1'b1, weight_address(f, t), stim_mem[base + f * NUM_TAPS + t],
                       rdata, slverr);
            check_value("pslverr on weight write", slverr, 1'b0);
         end
         apb_access(1'b1, bias_address(f), stim_mem[base + BIAS_OFFSET + f], rdata, slverr);
         check_value("pslverr on bias write", slverr, 1'b0);
      end
   endtask

   task automatic verify_coefficients(input int block);
      int          base;
      logic [15:0] rdata;
      logic        slverr;
      base = block * BLOCK_WORDS;
      for (int f = 0; f < NUM_FILTERS; f++) begin
         for (int t = 0; t < NUM_TAPS; t++) begin
            apb_access(1'b0, weight_address(f, t), 16'h0000, rdata, slverr);
            check_value($sformatf("weight %0d.%0d readback", f, t), rdata,
                        stim_mem[base + f * NUM_TAPS + t]);
            check_value("pslverr on weight read", slverr, 1'b0);
         end
         apb_access(1'b0, bias_address(f), 16'h0000, rdata, slverr);
         check_value($sformatf("bias %0d readback", f), rdata, stim_mem[base + BIAS_OFFSET + f]);
         check_value("pslverr on bias read", slverr, 1'b0);
      end
   endtask

   // tap past 8, filter 2, bias of filter 2
   task automatic probe_illegal_addresses();
      logic [7:0]  bad_addr [4];
      logic [15:0] rdata;
      logic        slverr;
      bad_addr = '{8'h09, 8'h0f, weight_address(2, 0), bias_address(2)};
      for (int i = 0; i < 4; i++) begin
         apb_access(1'b1, bad_addr[i], 16'h5a5a, rdata, slverr);
         check_value($sformatf("pslverr on write to %h", bad_addr[i]), slverr, 1'b1);
         apb_access(1'b0, bad_addr[i], 16'h0000, rdata, slverr);
         check_value($sformatf("pslverr on read of %h", bad_addr[i]), slverr, 1'b1);
         check_value($sformatf("prdata on read of %h", bad_addr[i]), rdata, 16'h0000);
      end
   endtask

   // -------------------------------------------------------------------
   // image run, drives the input stream and checks the output stream
   // -------------------------------------------------------------------

   task automatic run_image(input int block, input logic random_flow);
      int       base;
      int       in_count;
      int       out_count;
      logic     in_held;
      logic     gap;
      logic     stall;
      logic     stalled;
      feature_t held_data;
      string    where;
      base      = block * BLOCK_WORDS;
      in_count  = 0;
      out_count = 0;
      in_held   = 1'b0;
      stalled   = 1'b0;
      held_data = '0;
      while (out_count < NUM_FILTERS * IMAGE_SIZE) begin
         @(negedge clock);
         // a refused beat stays on the bus unchanged
         if (in_count < IMAGE_SIZE && !in_held) begin
            gap = 1'b0;
            if (random_flow) begin
               draw_rare_event(gap);
            end
            in_beat.valid = !gap;
            in_beat.last  = (in_count == IMAGE_SIZE - 1);
            in_beat.data  = stim_mem[base + PIXEL_OFFSET + in_count];
         end else if (in_count == IMAGE_SIZE) begin
            in_beat = '0;
         end
         stall = 1'b0;
         if (random_flow) begin
            draw_rare_event(stall);
         end
         out_ready = !stall;
         // both handshakes resolve at the coming rising edge
         #QUARTER;
         in_held = in_beat.valid && !in_ready;
         if (in_beat.valid && in_ready) begin
            in_count++;
         end
         if (stalled) begin
            check_value("valid held while stalled", out_beat.valid, 1'b1);
            check_value("data held while stalled", out_beat.data, held_data);
         end
         stalled   = out_beat.valid && !out_ready;
         held_data = out_beat.data;
         if (out_beat.valid && out_ready) begin
            where = $sformatf("filter %0d pixel %0d", out_count / IMAGE_SIZE,
                              out_count % IMAGE_SIZE);
            check_value({where, " data"}, out_beat.data,
                        stim_mem[base + RESULT_OFFSET + out_count]);
            check_value({where, " last"}, out_beat.last,
                        (out_count % IMAGE_SIZE) == IMAGE_SIZE - 1);
            out_count++;
         end
      end
      @(negedge clock);
      in_beat   = '0;
      out_ready = 1'b0;
   endtask

   // -------------------------------------------------------------------
   // test sequence
   // -------------------------------------------------------------------

   initial begin
      logic ready_seen;
      apb_req       = '0;
      in_beat       = '0;
      out_ready     = 1'b0;
      reset_n       = 1'b0;
      lfsr          = 32'hce71;
      check_count   = 0;
      error_count   = 0;
      errors_before = 0;
      test_count    = 0;
      $readmemh("bench/conv_stimulus.hex", stim_mem);

      // control outputs quiet in reset, ready soon after
      repeat (RESET_CYCLES - 1) @(negedge clock);
      #QUARTER;
      check_value("in_ready in reset", in_ready, 1'b0);
      check_value("out valid in reset", out_beat.valid, 1'b0);
      check_value("pslverr in reset", apb_rsp.pslverr, 1'b0);
      @(negedge clock);
      reset_n    = 1'b1;
      ready_seen = 1'b0;
      repeat (2) begin
         @(negedge clock);
         #QUARTER;
         ready_seen = ready_seen || in_ready;
      end
      check_value("in_ready within two cycles of reset", ready_seen, 1'b1);
      check_value("out valid after reset", out_beat.valid, 1'b0);
      check_value("pslverr after reset", apb_rsp.pslverr, 1'b0);
      finish_test("reset_state");

      write_coefficients(0);
      verify_coefficients(0);
      finish_test("coefficient_readback");

      probe_illegal_addresses();
      verify_coefficients(0);
      finish_test("illegal_access");

      run_image(0, 1'b0);
      finish_test("image_full_rate");

      run_image(0, 1'b1);
      finish_test("image_random_flow");

      write_coefficients(1);
      verify_coefficients(1);
      run_image(1, 1'b0);
      finish_test("relu_and_saturation");

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule : tb_conv_layer

// File: hdl/coef_regs.sv
`timescale 1ns/100ps

module coef_regs import conv_pkg::*; (
   input  logic                         clock,
   input  logic                         reset_n,
   input  apb_req_t                     apb_req,
   output apb_rsp_t                     apb_rsp,
   input  filter_index_t                filter_sel,
   output weight_t       [NUM_TAPS-1:0] weights,
   output weight_t                      bias
);

   weight_t [NUM_FILTERS-1:0][NUM_TAPS-1:0] weight_regs;
   weight_t [NUM_FILTERS-1:0]               bias_regs;

   coef_addr_u addr;
   logic       access;
   logic       weight_hit;
   logic       bias_hit;
   weight_t    read_value;

   // -------------------------------------------------------------------
   // address decode
   // -------------------------------------------------------------------

   assign addr   = apb_req.paddr;
   // no wait states, so every transfer ends in its access phase
   assign access = apb_req.psel && apb_req.penable;

   assign weight_hit = !addr.weight.region
                    && (addr.weight.tap < 4'(NUM_TAPS))
                    && (addr.weight.filter < 3'(NUM_FILTERS));
   assign bias_hit   = addr.bias.region
                    && (addr.bias.unused == '0)
                    && (addr.bias.filter < 3'(NUM_FILTERS));

   always_comb begin
      read_value = '0;
      if (weight_hit) begin
         read_value = weight_regs[addr.weight.filter][addr.weight.tap];
      end else if (bias_hit) begin
         read_value = bias_regs[addr.bias.filter];
      end
   end

   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access && !(weight_hit || bias_hit);
   // illegal reads see zero from read_value
   assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? read_value : '0;

   // register writes, coefficients start at zero
   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         weight_regs <= '0;
         bias_regs   <= '0;
      end else if (access && apb_req.pwrite) begin
         if (weight_hit) begin
            weight_regs[addr.weight.filter][addr.weight.tap] <= weight_t'(apb_req.pwdata);
         end
         if (bias_hit) begin
            bias_regs[addr.bias.filter] <= weight_t'(apb_req.pwdata);
         end
      end
   end

   // coefficient set of the filter now in its pass
   assign weights = weight_regs[filter_sel];
   assign bias    = bias_regs[filter_sel];

   a_penable_needs_psel : assert property (@(posedge clock) disable iff (!reset_n)
      apb_req.penable |-> apb_req.psel);

endmodule : coef_regs

// File: hdl/conv_layer.sv
`timescale 1ns/100ps

module conv_layer import conv_pkg::*; (
   input  logic          clock,
   input  logic          reset_n,
   input  apb_req_t      apb_req,
   output apb_rsp_t      apb_rsp,
   input  feature_beat_t in_beat,
   output logic          in_ready,
   output feature_beat_t out_beat,
   input  logic          out_ready
);

   // coefficient path
   filter_index_t                 filter_sel;
   weight_t       [NUM_TAPS-1:0]  weights;
   weight_t                       bias;

   // receive and window path
   logic          receiving;
   logic          rx_done;
   pixel_index_t  read_index;
   logic          read_enable;
   feature_t      pixel;
   logic          shift;
   window_t       window;
   logic          [NUM_TAPS-1:0]  tap_mask;

   // result and send path
   feature_t      result;
   logic          write_enable;
   pixel_index_t  write_index;
   logic          send_start;
   logic          tx_done;

   coef_regs i_coef_regs (
      .clock(clock), .reset_n(reset_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
      .filter_sel(filter_sel), .weights(weights), .bias(bias));

   feature_rx i_feature_rx (
      .clock(clock), .reset_n(reset_n), .in_beat(in_beat), .in_ready(in_ready),
      .receiving(receiving), .rx_done(rx_done), .read_index(read_index),
      .read_enable(read_enable), .pixel(pixel));

   window_shift i_window_shift (
      .clock(clock), .reset_n(reset_n), .shift(shift), .pixel(pixel),
      .window(window), .tap_mask(tap_mask));

   mac_tree i_mac_tree (
      .clock(clock), .reset_n(reset_n), .window(window), .tap_mask(tap_mask),
      .weights(weights), .bias(bias), .result(result));

   conv_sequencer i_conv_sequencer (
      .clock(clock), .reset_n(reset_n), .receiving(receiving), .rx_done(rx_done),
      .read_index(read_index), .read_enable(read_enable), .shift(shift),
      .filter_sel(filter_sel), .write_enable(write_enable), .write_index(write_index),
      .send_start(send_start), .tx_done(tx_done));

   feature_tx i_feature_tx (
      .clock(clock), .reset_n(reset_n), .write_enable(write_enable),
      .write_index(write_index), .result(result), .send_start(send_start),
      .out_beat(out_beat), .out_ready(out_ready), .tx_done(tx_done));

endmodule : conv_layer

// File: hdl/conv_pkg.sv
package conv_pkg;

   // -------------------------------------------------------------------
   // image and filter geometry
   // -------------------------------------------------------------------

   localparam int IMAGE_WIDTH  = 6;
   localparam int IMAGE_HEIGHT = 6;
   localparam int IMAGE_SIZE   = IMAGE_WIDTH * IMAGE_HEIGHT;
   localparam int FILTER_SIZE  = 3;
   localparam int NUM_TAPS     = FILTER_SIZE * FILTER_SIZE;
   localparam int NUM_FILTERS  = 2;
   localparam int FRAC_BITS    = 8;
   // two full image rows plus one filter row
   localparam int SHIFT_LENGTH = (FILTER_SIZE - 1) * IMAGE_WIDTH + FILTER_SIZE;
   // entries between the newest pixel and the centre tap
   localparam int CENTER_DELAY = (FILTER_SIZE / 2) * IMAGE_WIDTH + FILTER_SIZE / 2;

   // fixed point words, 8 fraction bits
   typedef logic signed [15:0] feature_t;
   typedef logic signed [15:0] weight_t;
   typedef logic signed [31:0] sum_t;
   typedef logic        [5:0]  pixel_index_t;
   typedef logic        [2:0]  filter_index_t;

   // stream beat, ready runs the other way
   typedef struct packed {
      logic     valid;
      logic     last;
      feature_t data;
   } feature_beat_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [15:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [15:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // coefficient address, region bit picks the view
   typedef union packed {
      struct packed {
         logic          region;
         filter_index_t filter;
         logic [3:0]    tap;
      } weight;
      struct packed {
         logic          region;
         filter_index_t filter;
         logic [3:0]    unused;
      } bias;
   } coef_addr_u;

   // tap 0 top left, row major
   typedef feature_t [NUM_TAPS-1:0] window_t;

endpackage : conv_pkg

// File: hdl/conv_sequencer.sv
`timescale 1ns/100ps

module conv_sequencer import conv_pkg::*; (
   input  logic          clock,
   input  logic          reset_n,
   output logic          receiving,
   input  logic          rx_done,
   output pixel_index_t  read_index,
   output logic          read_enable,
   output logic          shift,
   output filter_index_t filter_sel,
   output logic          write_enable,
   output pixel_index_t  write_index,
   output logic          send_start,
   input  logic          tx_done
);

   typedef enum logic [2:0] {ST_RECEIVE, ST_PASS, ST_DRAIN, ST_SEND, ST_DONE} state_t;

   // one step of the buffer write delay line
   typedef struct packed {
      logic         valid;
      pixel_index_t index;
   } write_slot_t;

   state_t            state;
   pixel_index_t      head_index;
   write_slot_t [2:0] write_pipe;
   logic              last_write;

   assign receiving   = (state == ST_RECEIVE);
   assign shift       = (state == ST_PASS);
   assign read_index  = head_index;
   assign read_enable = shift && (head_index < pixel_index_t'(IMAGE_SIZE));

   // -------------------------------------------------------------------
   // write strobe delay
   // -------------------------------------------------------------------

   // head k+7 read plus one cycle into the window and two through the mac tree
   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         write_pipe <= '0;
      end else begin
         write_pipe[0].valid <= shift && (head_index >= pixel_index_t'(CENTER_DELAY));
         write_pipe[0].index <= head_index - pixel_index_t'(CENTER_DELAY);
         write_pipe[2:1]     <= write_pipe[1:0];
      end
   end

   assign write_enable = write_pipe[2].valid;
   assign write_index  = write_pipe[2].index;
   assign last_write   = write_enable && (write_index == pixel_index_t'(IMAGE_SIZE - 1));
   assign send_start   = (state == ST_DRAIN) && last_write;

   // -------------------------------------------------------------------
   // state machine
   // -------------------------------------------------------------------

   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         state      <= ST_DONE;
         head_index <= '0;
         filter_sel <= '0;
      end else begin
         case (state)
            ST_DONE: begin
               filter_sel <= '0;
               state      <= ST_RECEIVE;
            end
            ST_RECEIVE: begin
               if (rx_done) begin
                  state <= ST_PASS;
               end
            end
            ST_PASS: begin
               head_index <= head_index + 1'b1;
               // last head pushes pixel 35 to the centre
               if (head_index == pixel_index_t'(IMAGE_SIZE + CENTER_DELAY - 1)) begin
                  head_index <= '0;
                  state      <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               if (last_write) begin
                  state <= ST_SEND;
               end
            end
            ST_SEND: begin
               if (tx_done && (filter_sel == filter_index_t'(NUM_FILTERS - 1))) begin
                  state <= ST_DONE;
               end else if (tx_done) begin
                  filter_sel <= filter_sel + 1'b1;
                  state      <= ST_PASS;
               end
            end
            default: begin
               state <= ST_DONE;
            end
         endcase
      end
   end

   // the image buffer only fills while no pass is reading it
   a_rx_done_in_receive : assert property (@(posedge clock) disable iff (!reset_n)
      rx_done |-> receiving);

endmodule : conv_sequencer

// File: hdl/feature_rx.sv
`timescale 1ns/100ps

module feature_rx import conv_pkg::*; (
   input  logic          clock,
   input  logic          reset_n,
   input  feature_beat_t in_beat,
   output logic          in_ready,
   input  logic          receiving,
   output logic          rx_done,
   input  pixel_index_t  read_index,
   input  logic          read_enable,
   output feature_t      pixel
);

   feature_t     image_buf [IMAGE_SIZE];
   pixel_index_t store_index;
   logic         accept;

   // ready follows the sequencer receive state
   assign in_ready = receiving;
   assign accept   = in_beat.valid && in_ready;
   // 36th beat closes the image
   assign rx_done  = accept && (store_index == pixel_index_t'(IMAGE_SIZE - 1));

   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         store_index <= '0;
      end else if (rx_done) begin
         store_index <= '0;
      end else if (accept) begin
         store_index <= store_index + 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (accept) begin
         image_buf[store_index] <= in_beat.data;
      end
   end

   // zeros once the head runs past the image
   assign pixel = read_enable ? image_buf[read_index] : '0;

   // sender framing must match the image size
   a_last_on_final_beat : assert property (@(posedge clock) disable iff (!reset_n)
      accept |-> (in_beat.last == (store_index == pixel_index_t'(IMAGE_SIZE - 1))));

endmodule : feature_rx

// File: hdl/feature_tx.sv
`timescale 1ns/100ps

module feature_tx import conv_pkg::*; (
   input  logic          clock,
   input  logic          reset_n,
   input  logic          write_enable,
   input  pixel_index_t  write_index,
   input  feature_t      result,
   input  logic          send_start,
   output feature_beat_t out_beat,
   input  logic          out_ready,
   output logic          tx_done
);

   feature_t     out_buf [IMAGE_SIZE];
   logic         sending;
   pixel_index_t send_index;
   logic         transfer;

   always_ff @(posedge clock) begin
      if (write_enable) begin
         out_buf[write_index] <= result;
      end
   end

   // beat held from the buffer until accepted
   assign out_beat.valid = sending;
   assign out_beat.last  = sending && (send_index == pixel_index_t'(IMAGE_SIZE - 1));
   assign out_beat.data  = out_buf[send_index];
   assign transfer       = sending && out_ready;
   assign tx_done        = transfer && out_beat.last;

   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         sending    <= 1'b0;
         send_index <= '0;
      end else if (send_start) begin
         sending    <= 1'b1;
         send_index <= '0;
      end else if (tx_done) begin
         sending    <= 1'b0;
         send_index <= '0;
      end else if (transfer) begin
         send_index <= send_index + 1'b1;
      end
   end

   // stalled beat keeps valid and data
   a_hold_while_stalled : assert property (@(posedge clock) disable iff (!reset_n)
      (out_beat.valid && !out_ready) |=> (out_beat.valid && $stable(out_beat.data)));

endmodule : feature_tx

// File: hdl/mac_tree.sv
`timescale 1ns/100ps

module mac_tree import conv_pkg::*; (
   input  logic                         clock,
   input  logic                         reset_n,
   input  window_t                      window,
   input  logic          [NUM_TAPS-1:0] tap_mask,
   input  weight_t       [NUM_TAPS-1:0] weights,
   input  weight_t                      bias,
   output feature_t                     result
);

   sum_t [NUM_TAPS-1:0]    product;
   sum_t [FILTER_SIZE-1:0] row_sum;
   sum_t                   total;

   // -------------------------------------------------------------------
   // stage 1 masked products and row sums
   // -------------------------------------------------------------------

   always_comb begin
      for (int t = 0; t < NUM_TAPS; t++) begin
         product[t] = '0;
         // back to 8 fraction bits
         if (tap_mask[t]) begin
            product[t] = (sum_t'(window[t]) * sum_t'(weights[t])) >>> FRAC_BITS;
         end
      end
   end

   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         row_sum <= '0;
      end else begin
         for (int r = 0; r < FILTER_SIZE; r++) begin
            row_sum[r] <= product[FILTER_SIZE * r]
                        + product[FILTER_SIZE * r + 1]
                        + product[FILTER_SIZE * r + 2];
         end
      end
   end

   // -------------------------------------------------------------------
   // stage 2 filter sum, bias, relu and saturation
   // -------------------------------------------------------------------

   assign total = row_sum[0] + row_sum[1] + row_sum[2] + sum_t'(bias);

   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         result <= '0;
      end else if (total < 0) begin
         result <= '0;
      end else if (total > 32'sd32767) begin
         result <= 16'sh7fff;
      end else begin
         result <= feature_t'(total);
      end
   end

endmodule : mac_tree

// File: hdl/window_shift.sv
`timescale 1ns/100ps

module window_shift import conv_pkg::*; (
   input  logic                clock,
   input  logic                reset_n,
   input  logic                shift,
   input  feature_t            pixel,
   output window_t             window,
   output logic [NUM_TAPS-1:0] tap_mask
);

   // entry 0 oldest, newest pixel enters at the top
   feature_t          line_reg [SHIFT_LENGTH];
   // image position of the pixel now under the centre tap
   logic signed [3:0] centre_row;
   logic signed [3:0] centre_col;

   // -------------------------------------------------------------------
   // line shift register
   // -------------------------------------------------------------------

   always_ff @(posedge clock) begin
      if (shift) begin
         for (int i = 0; i < SHIFT_LENGTH - 1; i++) begin
            line_reg[i] <= line_reg[i + 1];
         end
         line_reg[SHIFT_LENGTH - 1] <= pixel;
      end
   end

   // -------------------------------------------------------------------
   // centre position counters
   // -------------------------------------------------------------------

   // idle position is pixel -8 (row -2, col 4)
   // so the first shift puts pixel -7 at the centre
   always_ff @(posedge clock, negedge reset_n) begin
      if (!reset_n) begin
         centre_row <= -4'sd2;
         centre_col <= 4'sd4;
      end else if (!shift) begin
         centre_row <= -4'sd2;
         centre_col <= 4'sd4;
      end else if (centre_col == 4'(IMAGE_WIDTH - 1)) begin
         centre_col <= '0;
         centre_row <= centre_row + 4'sd1;
      end else begin
         centre_col <= centre_col + 4'sd1;
      end
   end

   // taps outside the image are masked, no wrap across row ends
   always_comb begin
      int tap_row;
      int tap_col;
      for (int i = 0; i < FILTER_SIZE; i++) begin
         for (int j = 0; j < FILTER_SIZE; j++) begin
            tap_row = int'(centre_row) + i - FILTER_SIZE / 2;
            tap_col = int'(centre_col) + j - FILTER_SIZE / 2;
            window[FILTER_SIZE * i + j]   = line_reg[IMAGE_WIDTH * i + j];
            tap_mask[FILTER_SIZE * i + j] = (tap_row >= 0) && (tap_row < IMAGE_HEIGHT)
                                         && (tap_col >= 0) && (tap_col < IMAGE_WIDTH);
         end
      end
   end

endmodule : window_shift

// File: sources.f
hdl/conv_pkg.sv
hdl/coef_regs.sv
hdl/feature_rx.sv
hdl/window_shift.sv
hdl/mac_tree.sv
hdl/conv_sequencer.sv
hdl/feature_tx.sv
hdl/conv_layer.sv
bench/tb_conv_layer.sv
